//--- logic/rta_pkg.sv
// sizes are fixed here; the stack core field is two address bits, so NUM_RT must stay at 4
`default_nettype none

package rta_pkg;

  // ========================================
  // sizes and widths
  // ========================================

  // number of ray-tracing core slots
  localparam int NUM_RT   = 4;
  localparam int RT_IDX_W = $clog2(NUM_RT);

  // triangle store size and id width
  localparam int NUM_TRI  = 512;
  localparam int TRI_ID_W = 9;

  // per-core stack bank, 128-bit words
  localparam int STACK_AW    = 8;
  localparam int STACK_DEPTH = 2 ** STACK_AW;

  // instruction and constant memories, 32-bit words
  localparam int WORD_AW    = 8;
  localparam int WORD_DEPTH = 2 ** WORD_AW;

  localparam int WORD_W   = 32;
  localparam int DATA_W   = 128;
  localparam int VERTEX_W = 96;
  localparam int CMD_AW   = 16;

  // ========================================
  // load command address fields
  // ========================================

  // stack commands carry the core index above the bank address
  localparam int STACK_CORE_LSB = 8;
  // triangle commands carry the beat number below the triangle id
  localparam int TRI_BEAT_W  = 2;
  localparam int TRI_BEAT_AW = TRI_ID_W + TRI_BEAT_W;

  // region codes of a load command
  localparam logic [1:0] REGION_STACK = 2'd0;
  localparam logic [1:0] REGION_INST  = 2'd1;
  localparam logic [1:0] REGION_CONST = 2'd2;
  localparam logic [1:0] REGION_TRI   = 2'd3;

  // ========================================
  // shared types
  // ========================================

  // one load word, read as four plain words or as a vertex with its attribute
  // word 0 and the attribute word occupy the same low 32 bits
  typedef union packed {
    logic [3:0][WORD_W-1:0] words;
    struct packed {
      logic [VERTEX_W-1:0] vertex;
      logic [WORD_W-1:0]   attr;
    } vtx;
  } load_word_u;

  // a command from the load stream, readback set means a stack read
  typedef struct packed {
    logic              readback;
    logic [1:0]        region;
    logic [CMD_AW-1:0] addr;
    load_word_u        data;
  } load_cmd_t;

  // stack request from one core
  typedef struct packed {
    logic                we;
    logic                re;
    logic [STACK_AW-1:0] addr;
    logic [DATA_W-1:0]   data;
  } stack_req_t;

  // triangle lookup response
  typedef struct packed {
    logic                valid;
    logic                sid;
    logic [VERTEX_W-1:0] vertex0;
    logic [VERTEX_W-1:0] vertex1;
    logic [VERTEX_W-1:0] vertex2;
  } tri_rsp_t;

endpackage

`default_nettype wire

//--- logic/rta_loader.sv
// two register stages per command; readbacks to regions other than the stack are dropped
`timescale 1ns/1ps
`default_nettype none

module rta_loader (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                load_valid,
  input  rta_pkg::load_cmd_t                  load_cmd,
  output logic                                ld_stack_we,
  output logic                                ld_stack_re,
  output logic [rta_pkg::RT_IDX_W-1:0]        ld_core,
  output logic [rta_pkg::STACK_AW-1:0]        ld_stack_addr,
  output rta_pkg::load_word_u                 ld_wdata,
  output logic                                inst_we,
  output logic                                const_we,
  output logic                                tri_we,
  output logic [rta_pkg::TRI_BEAT_AW-1:0]     tri_beat_addr,
  input  logic                                ld_rd_rdy,
  input  logic [rta_pkg::DATA_W-1:0]          bank_data [rta_pkg::NUM_RT-1:0],
  output logic                                result_valid,
  output logic [rta_pkg::DATA_W-1:0]          result_data
);

  logic                         cmd_v;
  rta_pkg::load_cmd_t           cmd_q;
  logic                         cmd_wr;
  logic                         cmd_rd;
  logic [rta_pkg::RT_IDX_W-1:0] rb_core;

  // ========================================
  // stage 1, command register
  // ========================================

  always_ff @(posedge clk) begin
    if (rst) begin
      cmd_v <= 1'b0;
    end else begin
      cmd_v <= load_valid;
    end
  end

  // the command body only matters while cmd_v is high
  always_ff @(posedge clk) begin
    cmd_q <= load_cmd;
  end

  assign cmd_wr = cmd_v && !cmd_q.readback;
  assign cmd_rd = cmd_v && cmd_q.readback;

  // ========================================
  // stage 2, decoded strobes
  // ========================================

  // at most one of these is high in any cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      ld_stack_we <= 1'b0;
      ld_stack_re <= 1'b0;
      inst_we     <= 1'b0;
      const_we    <= 1'b0;
      tri_we      <= 1'b0;
    end else begin
      ld_stack_we <= cmd_wr && (cmd_q.region == rta_pkg::REGION_STACK);
      ld_stack_re <= cmd_rd && (cmd_q.region == rta_pkg::REGION_STACK);
      inst_we     <= cmd_wr && (cmd_q.region == rta_pkg::REGION_INST);
      const_we    <= cmd_wr && (cmd_q.region == rta_pkg::REGION_CONST);
      tri_we      <= cmd_wr && (cmd_q.region == rta_pkg::REGION_TRI);
    end
  end

  // address fields are sliced per region, the word memories reuse the bank address
  always_ff @(posedge clk) begin
    ld_core       <= cmd_q.addr[rta_pkg::STACK_CORE_LSB +: rta_pkg::RT_IDX_W];
    ld_stack_addr <= cmd_q.addr[rta_pkg::STACK_AW-1:0];
    tri_beat_addr <= cmd_q.addr[rta_pkg::TRI_BEAT_AW-1:0];
    ld_wdata      <= cmd_q.data;
  end

  // ========================================
  // readback result
  // ========================================

  // the core index is held here because ld_core may move on to the next command
  always_ff @(posedge clk) begin
    if (ld_stack_re)
      rb_core <= ld_core;
  end

  assign result_valid = ld_rd_rdy;
  assign result_data  = bank_data[rb_core];

endmodule

`default_nettype wire

//--- logic/rta_stack_mem.sv
// single-port banks, read-first; a loader access to a bank drops that core's request that cycle
`timescale 1ns/1ps
`default_nettype none

module rta_stack_mem (
  input  logic                         clk,
  input  logic                         rst,
  input  rta_pkg::stack_req_t          core_req [rta_pkg::NUM_RT-1:0],
  input  logic                         ld_stack_we,
  input  logic                         ld_stack_re,
  input  logic [rta_pkg::RT_IDX_W-1:0] ld_core,
  input  logic [rta_pkg::STACK_AW-1:0] ld_stack_addr,
  input  rta_pkg::load_word_u          ld_wdata,
  output logic [rta_pkg::NUM_RT-1:0]   core_rd_rdy,
  output logic [rta_pkg::DATA_W-1:0]   core_rd_data [rta_pkg::NUM_RT-1:0],
  output logic                         ld_rd_rdy,
  output logic [rta_pkg::DATA_W-1:0]   bank_data [rta_pkg::NUM_RT-1:0]
);

  for (genvar b = 0; b < rta_pkg::NUM_RT; b++) begin : g_bank
    logic [rta_pkg::DATA_W-1:0] mem [rta_pkg::STACK_DEPTH];
    logic [rta_pkg::DATA_W-1:0] rd_q;
    logic                       rdy_q;
    logic                       ld_hit;

    // the loader owns this bank for the cycle when it targets it
    assign ld_hit = (ld_stack_we || ld_stack_re) && (ld_core == rta_pkg::RT_IDX_W'(b));

    always_ff @(posedge clk) begin
      if (ld_hit) begin
        if (ld_stack_we)
          mem[ld_stack_addr] <= ld_wdata;
        if (ld_stack_re)
          rd_q <= mem[ld_stack_addr];
      end else begin
        // a core read in the same cycle as its write returns the old word
        if (core_req[b].we)
          mem[core_req[b].addr] <= core_req[b].data;
        if (core_req[b].re)
          rd_q <= mem[core_req[b].addr];
      end
    end

    // ready only for a core read that actually got the port
    always_ff @(posedge clk) begin
      if (rst) begin
        rdy_q <= 1'b0;
      end else begin
        rdy_q <= core_req[b].re && !ld_hit;
      end
    end

    // one read register serves both requesters of the bank
    assign core_rd_rdy[b]  = rdy_q;
    assign core_rd_data[b] = rd_q;
    assign bank_data[b]    = rd_q;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ld_rd_rdy <= 1'b0;
    end else begin
      ld_rd_rdy <= ld_stack_re;
    end
  end

endmodule

`default_nettype wire

//--- logic/rta_word_mem.sv
// no reset on contents; a read and a write to one address in the same cycle return the old word
`timescale 1ns/1ps
`default_nettype none

module rta_word_mem (
  input  logic                        clk,
  input  logic                        we,
  input  logic [rta_pkg::WORD_AW-1:0] waddr,
  input  logic [rta_pkg::WORD_W-1:0]  wdata,
  input  logic [rta_pkg::WORD_AW-1:0] raddr,
  output logic [rta_pkg::WORD_W-1:0]  rdata
);

  // ========================================
  // storage
  // ========================================

  logic [rta_pkg::WORD_W-1:0] mem [rta_pkg::WORD_DEPTH];

  // the loader write is broadcast, every core copy sees the same strobe
  always_ff @(posedge clk) begin
    if (we)
      mem[waddr] <= wdata;
  end

  // the core side reads every cycle, there is no read strobe
  always_ff @(posedge clk) begin
    rdata <= mem[raddr];
  end

endmodule

`default_nettype wire

//--- logic/rta_tri_mem.sv
// beat 3 writes are ignored; a lookup in the same cycle as a write sees the state before it
`timescale 1ns/1ps
`default_nettype none

module rta_tri_mem (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            tri_we,
  input  logic [rta_pkg::TRI_BEAT_AW-1:0] tri_beat_addr,
  input  rta_pkg::load_word_u             ld_wdata,
  input  logic                            tri_re,
  input  logic [rta_pkg::TRI_ID_W-1:0]    tri_id,
  output logic                            tri_rdy,
  output rta_pkg::tri_rsp_t               tri_rsp
);

  logic [rta_pkg::VERTEX_W-1:0]   v0_mem [rta_pkg::NUM_TRI];
  logic [rta_pkg::VERTEX_W-1:0]   v1_mem [rta_pkg::NUM_TRI];
  logic [rta_pkg::VERTEX_W-1:0]   v2_mem [rta_pkg::NUM_TRI];
  logic [rta_pkg::NUM_TRI-1:0]    tri_sid;
  logic [rta_pkg::NUM_TRI-1:0]    tri_valid;
  logic [rta_pkg::TRI_ID_W-1:0]   wr_id;
  logic [rta_pkg::TRI_BEAT_W-1:0] wr_beat;
  logic                           rsp_valid;
  logic                           rsp_sid;
  logic [rta_pkg::VERTEX_W-1:0]   rsp_v0;
  logic [rta_pkg::VERTEX_W-1:0]   rsp_v1;
  logic [rta_pkg::VERTEX_W-1:0]   rsp_v2;

  assign wr_id   = tri_beat_addr[rta_pkg::TRI_BEAT_W +: rta_pkg::TRI_ID_W];
  assign wr_beat = tri_beat_addr[rta_pkg::TRI_BEAT_W-1:0];

  // ========================================
  // triangle data, loaded one vertex per beat
  // ========================================

  always_ff @(posedge clk) begin
    if (tri_we) begin
      case (wr_beat)
        2'd0: v0_mem[wr_id] <= ld_wdata.vtx.vertex;
        2'd1: v1_mem[wr_id] <= ld_wdata.vtx.vertex;
        2'd2: begin
          v2_mem[wr_id]  <= ld_wdata.vtx.vertex;
          tri_sid[wr_id] <= ld_wdata.vtx.attr[0];
        end
        default: ;
      endcase
    end
    if (tri_re) begin
      rsp_v0  <= v0_mem[tri_id];
      rsp_v1  <= v1_mem[tri_id];
      rsp_v2  <= v2_mem[tri_id];
      rsp_sid <= tri_sid[tri_id];
    end
  end

  // ========================================
  // valid bits and lookup strobe
  // ========================================

  // beat 0 opens a reload, so a partly rewritten triangle reads as invalid
  always_ff @(posedge clk) begin
    if (rst) begin
      tri_valid <= '0;
      tri_rdy   <= 1'b0;
      rsp_valid <= 1'b0;
    end else begin
      if (tri_we && wr_beat == 2'd0)
        tri_valid[wr_id] <= 1'b0;
      if (tri_we && wr_beat == 2'd2)
        tri_valid[wr_id] <= 1'b1;
      tri_rdy <= tri_re;
      if (tri_re)
        rsp_valid <= tri_valid[tri_id];
    end
  end

  // an invalid triangle answers with all fields zero
  always_comb begin
    tri_rsp.valid   = rsp_valid;
    tri_rsp.sid     = rsp_valid && rsp_sid;
    tri_rsp.vertex0 = rsp_valid ? rsp_v0 : '0;
    tri_rsp.vertex1 = rsp_valid ? rsp_v1 : '0;
    tri_rsp.vertex2 = rsp_valid ? rsp_v2 : '0;
  end

endmodule

`default_nettype wire

//--- logic/rta_mem_top.sv
// core ports are plain strobes with fixed latency; no host interface and no back-pressure
`timescale 1ns/1ps
`default_nettype none

module rta_mem_top (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            load_valid,
  input  rta_pkg::load_cmd_t              load_cmd,
  input  rta_pkg::stack_req_t             core_stack_req [rta_pkg::NUM_RT-1:0],
  input  logic [rta_pkg::WORD_AW-1:0]     inst_addr [rta_pkg::NUM_RT-1:0],
  input  logic [rta_pkg::WORD_AW-1:0]     const_addr [rta_pkg::NUM_RT-1:0],
  input  logic                            tri_re,
  input  logic [rta_pkg::TRI_ID_W-1:0]    tri_id,
  output logic [rta_pkg::NUM_RT-1:0]      core_rd_rdy,
  output logic [rta_pkg::DATA_W-1:0]      core_rd_data [rta_pkg::NUM_RT-1:0],
  output logic [rta_pkg::WORD_W-1:0]      inst_data [rta_pkg::NUM_RT-1:0],
  output logic [rta_pkg::WORD_W-1:0]      const_data [rta_pkg::NUM_RT-1:0],
  output logic                            result_valid,
  output logic [rta_pkg::DATA_W-1:0]      result_data,
  output logic                            tri_rdy,
  output rta_pkg::tri_rsp_t               tri_rsp
);

  // ========================================
  // loader to memory wiring
  // ========================================

  logic                            ld_stack_we;
  logic                            ld_stack_re;
  logic [rta_pkg::RT_IDX_W-1:0]    ld_core;
  logic [rta_pkg::STACK_AW-1:0]    ld_stack_addr;
  rta_pkg::load_word_u             ld_wdata;
  logic                            inst_we;
  logic                            const_we;
  logic                            tri_we;
  logic [rta_pkg::TRI_BEAT_AW-1:0] tri_beat_addr;
  logic                            ld_rd_rdy;
  logic [rta_pkg::DATA_W-1:0]      bank_data [rta_pkg::NUM_RT-1:0];

  rta_loader u_loader (
    .clk           (clk),
    .rst           (rst),
    .load_valid    (load_valid),
    .load_cmd      (load_cmd),
    .ld_stack_we   (ld_stack_we),
    .ld_stack_re   (ld_stack_re),
    .ld_core       (ld_core),
    .ld_stack_addr (ld_stack_addr),
    .ld_wdata      (ld_wdata),
    .inst_we       (inst_we),
    .const_we      (const_we),
    .tri_we        (tri_we),
    .tri_beat_addr (tri_beat_addr),
    .ld_rd_rdy     (ld_rd_rdy),
    .bank_data     (bank_data),
    .result_valid  (result_valid),
    .result_data   (result_data)
  );

  rta_stack_mem u_stack (
    .clk           (clk),
    .rst           (rst),
    .core_req      (core_stack_req),
    .ld_stack_we   (ld_stack_we),
    .ld_stack_re   (ld_stack_re),
    .ld_core       (ld_core),
    .ld_stack_addr (ld_stack_addr),
    .ld_wdata      (ld_wdata),
    .core_rd_rdy   (core_rd_rdy),
    .core_rd_data  (core_rd_data),
    .ld_rd_rdy     (ld_rd_rdy),
    .bank_data     (bank_data)
  );

  // each core gets its own instruction and constant copy, all loaded alike
  // the word memories take word 0 of the load word and the bank address field
  for (genvar c = 0; c < rta_pkg::NUM_RT; c++) begin : g_core
    rta_word_mem u_inst (
      .clk   (clk),
      .we    (inst_we),
      .waddr (ld_stack_addr),
      .wdata (ld_wdata.words[0]),
      .raddr (inst_addr[c]),
      .rdata (inst_data[c])
    );

    rta_word_mem u_const (
      .clk   (clk),
      .we    (const_we),
      .waddr (ld_stack_addr),
      .wdata (ld_wdata.words[0]),
      .raddr (const_addr[c]),
      .rdata (const_data[c])
    );
  end

  rta_tri_mem u_tri (
    .clk           (clk),
    .rst           (rst),
    .tri_we        (tri_we),
    .tri_beat_addr (tri_beat_addr),
    .ld_wdata      (ld_wdata),
    .tri_re        (tri_re),
    .tri_id        (tri_id),
    .tri_rdy       (tri_rdy),
    .tri_rsp       (tri_rsp)
  );

endmodule

`default_nettype wire

//--- bench/rta_asserts.sv
// one checker bound twice; the triangle binding uses lane 0 only and has no loader side
`timescale 1ns/1ps
`default_nettype none

module rta_stack_asserts (
  input wire logic       clk,
  input wire logic       rst,
  input wire logic       ld_access,
  input wire logic [1:0] ld_core,
  input wire logic [3:0] req,
  input wire logic [3:0] rdy,
  input wire logic       ld_re,
  input wire logic       ld_rdy
);

  for (genvar b = 0; b < 4; b++) begin : g_lane
    // a bank held by the loader serves no core in that cycle
    a_ld_wins: assert property (@(posedge clk) disable iff (rst)
      (ld_access && ld_core == 2'(b)) |=> !rdy[b])
      else $error("core %0d served while the loader held its bank", b);
    a_rdy_after_req: assert property (@(posedge clk) disable iff (rst) rdy[b] |-> $past(req[b]))
      else $error("ready on lane %0d without a request one cycle before", b);
    a_req_served: assert property (@(posedge clk) disable iff (rst)
      (req[b] && !(ld_access && ld_core == 2'(b))) |=> rdy[b])
      else $error("request on lane %0d not answered after one cycle", b);
  end

  a_ld_rdy: assert property (@(posedge clk) disable iff (rst) ld_rdy |-> $past(ld_re))
    else $error("loader read ready without a loader read");

endmodule

bind rta_stack_mem rta_stack_asserts u_stack_asserts (
  .clk (clk), .rst (rst), .ld_access (ld_stack_we || ld_stack_re), .ld_core (ld_core),
  .req ({core_req[3].re, core_req[2].re, core_req[1].re, core_req[0].re}),
  .rdy (core_rd_rdy), .ld_re (ld_stack_re), .ld_rdy (ld_rd_rdy)
);

bind rta_tri_mem rta_stack_asserts u_tri_asserts (
  .clk (clk), .rst (rst), .ld_access (1'b0), .ld_core (2'b0), .req ({3'b0, tri_re}),
  .rdy ({3'b0, tri_rdy}), .ld_re (1'b0), .ld_rdy (1'b0)
);

`default_nettype wire

//--- bench/rta_tb.sv
// drives the memory top level as four cores and one loader; unwritten memory words are never read
`timescale 1ns/1ps
`default_nettype none

module rta_tb;

  typedef struct packed {
    int           due;
    logic [289:0] val;
  } exp_t;

  logic                            clk;
  logic                            rst;
  logic                            load_valid;
  rta_pkg::load_cmd_t              load_cmd;
  rta_pkg::stack_req_t             core_req [rta_pkg::NUM_RT-1:0];
  logic [rta_pkg::WORD_AW-1:0]     inst_addr [rta_pkg::NUM_RT-1:0];
  logic [rta_pkg::WORD_AW-1:0]     const_addr [rta_pkg::NUM_RT-1:0];
  logic                            tri_re;
  logic [rta_pkg::TRI_ID_W-1:0]    tri_id;
  logic [rta_pkg::NUM_RT-1:0]      core_rd_rdy;
  logic [rta_pkg::DATA_W-1:0]      core_rd_data [rta_pkg::NUM_RT-1:0];
  logic [rta_pkg::WORD_W-1:0]      inst_data [rta_pkg::NUM_RT-1:0];
  logic [rta_pkg::WORD_W-1:0]      const_data [rta_pkg::NUM_RT-1:0];
  logic                            result_valid;
  logic [rta_pkg::DATA_W-1:0]      result_data;
  logic                            tri_rdy;
  rta_pkg::tri_rsp_t               tri_rsp;

  // model arrays follow the writes in the order they are issued
  logic [127:0] stk_m [4][256];
  logic [31:0]  inst_m [256];
  logic [31:0]  const_m [256];
  logic [95:0]  tv0 [512];
  logic [95:0]  tv1 [512];
  logic [95:0]  tv2 [512];
  logic         tsid [512];
  logic         tval [512];

  // each pending response is tagged with the cycle it must appear in
  exp_t res_q [$];
  exp_t core_q [4][$];
  exp_t inst_q [4][$];
  exp_t const_q [4][$];
  exp_t tri_q [$];

  int          cyc = 0;
  int          errors = 0;
  int          timeouts = 0;
  logic [31:0] lfsr = 32'h6e71_6f54;
  logic [7:0]  wa [8];
  logic [127:0] r;
  logic [1:0]  pc;

  rta_mem_top DUT (
    .clk            (clk),
    .rst            (rst),
    .load_valid     (load_valid),
    .load_cmd       (load_cmd),
    .core_stack_req (core_req),
    .inst_addr      (inst_addr),
    .const_addr     (const_addr),
    .tri_re         (tri_re),
    .tri_id         (tri_id),
    .core_rd_rdy    (core_rd_rdy),
    .core_rd_data   (core_rd_data),
    .inst_data      (inst_data),
    .const_data     (const_data),
    .result_valid   (result_valid),
    .result_data    (result_data),
    .tri_rdy        (tri_rdy),
    .tri_rsp        (tri_rsp)
  );

  // ========================================
  // clock, cycle count, random bits
  // ========================================

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  // taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [127:0] take_bits(input int n);
    logic [127:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[126:0], lfsr[0]};
    end
    return v;
  endfunction

  // the model gives the expected read value in the layout of the matching DUT output
  // an invalid triangle reads as all zero
  function automatic logic [289:0] rta_ref(input logic [1:0] kind, input logic [1:0] idx,
                                          input logic [8:0] addr);
    logic [289:0] v;
    v = '0;
    case (kind)
      rta_pkg::REGION_STACK: v[127:0] = stk_m[idx][addr[7:0]];
      rta_pkg::REGION_INST:  v[31:0] = inst_m[addr[7:0]];
      rta_pkg::REGION_CONST: v[31:0] = const_m[addr[7:0]];
      default: begin
        if (tval[addr])
          v = {1'b1, tsid[addr], tv0[addr], tv1[addr], tv2[addr]};
      end
    endcase
    return v;
  endfunction

  // ========================================
  // comparing process
  // ========================================

  task report(input string what, input logic [289:0] got, input logic [289:0] exp);
    errors++;
    $display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
  endtask

  // outputs are registered, so they are steady at the falling edge
  always @(negedge clk) begin : compare
    exp_t e;
    if (!rst) begin
      if (res_q.size() != 0 && res_q[0].due == cyc) begin
        e = res_q.pop_front();
        assert (result_valid && result_data == e.val[127:0])
          else report("loader readback", {161'b0, result_valid, result_data}, e.val);
      end else begin
        assert (!result_valid) else report("stray result_valid", 290'(result_valid), '0);
      end
      for (int c = 0; c < 4; c++) begin
        if (core_q[c].size() != 0 && core_q[c][0].due == cyc) begin
          e = core_q[c].pop_front();
          assert (core_rd_rdy[c] && core_rd_data[c] == e.val[127:0])
            else report("core stack read", {161'b0, core_rd_rdy[c], core_rd_data[c]}, e.val);
        end else begin
          assert (!core_rd_rdy[c])
            else report("stray core_rd_rdy", 290'(core_rd_rdy), '0);
        end
        if (inst_q[c].size() != 0 && inst_q[c][0].due == cyc) begin
          e = inst_q[c].pop_front();
          assert (inst_data[c] == e.val[31:0])
            else report("inst read", 290'(inst_data[c]), e.val);
        end
        if (const_q[c].size() != 0 && const_q[c][0].due == cyc) begin
          e = const_q[c].pop_front();
          assert (const_data[c] == e.val[31:0])
            else report("const read", 290'(const_data[c]), e.val);
        end
      end
      if (tri_q.size() != 0 && tri_q[0].due == cyc) begin
        e = tri_q.pop_front();
        assert (tri_rdy && tri_rsp == e.val) else report("triangle lookup", tri_rsp, e.val);
      end else begin
        assert (!tri_rdy) else report("stray tri_rdy", 290'(tri_rdy), '0);
      end
    end
  end

  // ========================================
  // stimulus tasks
  // ========================================

  task clear_inputs();
    load_valid = 1'b0;
    tri_re = 1'b0;
    for (int c = 0; c < 4; c++) begin
      core_req[c].we = 1'b0;
      core_req[c].re = 1'b0;
    end
  endtask

  task idle(input int n);
    repeat (n) begin
      @(negedge clk);
      clear_inputs();
    end
  endtask

  // writes of a load command go to the model at once and readbacks queue a result
  task issue_load(input logic rb, input logic [1:0] region, input logic [15:0] addr,
                  input logic [127:0] data);
    @(negedge clk);
    clear_inputs();
    load_valid = 1'b1;
    load_cmd.readback = rb;
    load_cmd.region = region;
    load_cmd.addr = addr;
    load_cmd.data = data;
    if (rb) begin
      res_q.push_back('{cyc + 3, rta_ref(region, addr[9:8], {1'b0, addr[7:0]})});
    end else begin
      case (region)
        rta_pkg::REGION_STACK: stk_m[addr[9:8]][addr[7:0]] = data;
        rta_pkg::REGION_INST:  inst_m[addr[7:0]] = data[31:0];
        rta_pkg::REGION_CONST: const_m[addr[7:0]] = data[31:0];
        default: begin
          // beat 0 reopens the triangle and beat 2 completes it
          if (addr[1:0] == 2'd0) begin
            tv0[addr[10:2]] = data[127:32];
            tval[addr[10:2]] = 1'b0;
          end else if (addr[1:0] == 2'd1) begin
            tv1[addr[10:2]] = data[127:32];
          end else if (addr[1:0] == 2'd2) begin
            tv2[addr[10:2]] = data[127:32];
            tsid[addr[10:2]] = data[0];
            tval[addr[10:2]] = 1'b1;
          end
        end
      endcase
    end
  endtask

  // the surface id follows bit 0 of the triangle id so that both values get looked up
  task load_triangle(input logic [8:0] id, input int beats);
    logic [127:0] d;
    for (int b = 0; b < beats; b++) begin
      d = take_bits(128);
      if (b == 2)
        d[0] = id[0];
      issue_load(1'b0, rta_pkg::REGION_TRI, {5'b0, id, 2'(b)}, d);
    end
  endtask

  function automatic int pending();
    int n;
    n = res_q.size() + tri_q.size();
    for (int c = 0; c < 4; c++)
      n += core_q[c].size() + inst_q[c].size() + const_q[c].size();
    return n;
  endfunction

  task wait_drained();
    int t;
    t = 0;
    while (pending() != 0 && t < 50) begin
      @(negedge clk);
      clear_inputs();
      t++;
    end
    if (pending() != 0) begin
      timeouts++;
      $display("Timeout: %0d expected responses never arrived", pending());
    end
  endtask

  task lookup(input logic [8:0] id);
    @(negedge clk);
    clear_inputs();
    tri_re = 1'b1;
    tri_id = id;
    tri_q.push_back('{cyc + 1, rta_ref(rta_pkg::REGION_TRI, 2'd0, id)});
  endtask

  // ========================================
  // test sequence
  // ========================================

  initial begin
    rst = 1'b1;
    load_valid = 1'b0;
    load_cmd = '0;
    tri_re = 1'b0;
    tri_id = '0;
    for (int c = 0; c < 4; c++) begin
      core_req[c] = '0;
      inst_addr[c] = '0;
      const_addr[c] = '0;
    end
    for (int i = 0; i < 512; i++)
      tval[i] = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    // any pulse in this quiet period is flagged as stray
    idle(6);

    // broadcast instruction and constant loads
    for (int i = 0; i < 8; i++) begin
      r = take_bits(8);
      wa[i] = r[7:0];
      issue_load(1'b0, rta_pkg::REGION_INST, {8'b0, wa[i]}, take_bits(128));
      issue_load(1'b0, rta_pkg::REGION_CONST, {8'b0, wa[i]}, take_bits(128));
    end
    idle(4);
    for (int i = 0; i < 8; i++) begin
      @(negedge clk);
      for (int c = 0; c < 4; c++) begin
        inst_addr[c] = wa[i];
        const_addr[c] = wa[(i + c) % 8];
        inst_q[c].push_back('{cyc + 1, rta_ref(rta_pkg::REGION_INST, 2'd0, {1'b0, wa[i]})});
        const_q[c].push_back('{cyc + 1,
          rta_ref(rta_pkg::REGION_CONST, 2'd0, {1'b0, wa[(i + c) % 8]})});
      end
    end
    wait_drained();

    // all cores write their private stacks at the same addresses with their own data
    for (int i = 0; i < 8; i++) begin
      @(negedge clk);
      clear_inputs();
      for (int c = 0; c < 4; c++) begin
        r = take_bits(128);
        core_req[c].we = 1'b1;
        core_req[c].addr = 8'(i);
        core_req[c].data = r;
        stk_m[c][i] = r;
      end
    end
    for (int i = 0; i < 8; i++) begin
      @(negedge clk);
      clear_inputs();
      for (int c = 0; c < 4; c++) begin
        core_req[c].re = 1'b1;
        core_req[c].addr = 8'(7 - i);
        core_q[c].push_back('{cyc + 1,
          rta_ref(rta_pkg::REGION_STACK, 2'(c), 9'(7 - i))});
      end
    end
    wait_drained();

    // loader overwrites some core words, then reads back every core's words
    for (int i = 0; i < 6; i++)
      issue_load(1'b0, rta_pkg::REGION_STACK, {6'b0, 2'(i % 4), 8'(i)}, take_bits(128));
    for (int i = 0; i < 8; i++)
      issue_load(1'b1, rta_pkg::REGION_STACK, {6'b0, 2'(i % 4), 8'(i)}, '0);
    idle(1);
    wait_drained();

    // a loader readback and a core read meet at bank 1 and the retry is served
    pc = 2'd1;
    issue_load(1'b1, rta_pkg::REGION_STACK, {6'b0, pc, 8'd3}, '0);
    idle(1);
    @(negedge clk);
    core_req[1].re = 1'b1;
    core_req[1].addr = 8'd5;
    @(negedge clk);
    core_req[1].re = 1'b1;
    core_req[1].addr = 8'd5;
    core_q[1].push_back('{cyc + 1, rta_ref(rta_pkg::REGION_STACK, pc, 9'd5)});
    idle(2);
    wait_drained();

    // two of the triangles are left half reloaded
    load_triangle(9'd5, 3);
    load_triangle(9'd300, 3);
    load_triangle(9'd20, 3);
    load_triangle(9'd21, 3);
    load_triangle(9'd20, 1);
    load_triangle(9'd21, 2);
    idle(4);
    lookup(9'd5);
    lookup(9'd300);
    lookup(9'd100);
    lookup(9'd20);
    lookup(9'd21);
    idle(1);
    wait_drained();
    idle(3);

    $display("Checks finished with %0d errors and %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
logic/rta_pkg.sv
logic/rta_loader.sv
logic/rta_stack_mem.sv
logic/rta_word_mem.sv
logic/rta_tri_mem.sv
logic/rta_mem_top.sv
bench/rta_asserts.sv
bench/rta_tb.sv

//--- Makefile
# Verilator build and run for the memory subsystem testbench

VERILATOR ?= verilator
TOP       ?= rta_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= filelist.f
VFLAGS    ?= --binary --timing --assert -j 0
SIM       = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf $(BUILD_DIR)
